/* source/vs_settings.svh */
// formats and a 640x480 screen are fixed; other sizes need new shift-add terms in vs_viewport
`ifndef VS_SETTINGS_SVH
`define VS_SETTINGS_SVH

// fraction bits
`define VS_FRAC_WORLD 8    // world, matrix and clip, Q8.8
`define VS_FRAC_NDC 14     // ndc, Q2.14

// word widths
`define VS_FIX_W 16        // every fixed-point word
`define VS_SCR_W 20        // screen coordinates and edge values

// screen
`define VS_HALF_W 320
`define VS_HALF_H 240

// divider magnitude width
// 16-bit numerator magnitude with the ndc fraction appended
`define VS_DIV_W 30

`endif

/* source/vs_pkg.sv */
// types only; widths come from vs_settings.svh, vertex order is v[0], v[1], v[2]
`include "vs_settings.svh"

package vs_pkg;

	////////////////////////////////////////////////////////////////////////////
	// scalar words
	////////////////////////////////////////////////////////////////////////////
	typedef logic signed [`VS_FIX_W-1:0] fix_t;   // Q8.8 or Q2.14
	typedef logic signed [`VS_SCR_W-1:0] scr_t;   // integer pixels

	////////////////////////////////////////////////////////////////////////////
	// triangle payloads, one per stage boundary
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vtx_world_t;

	typedef struct packed {
		vtx_world_t [2:0] v;
	} tri_world_t;

	// rows 0, 1 and 3 of view-projection; column 3 multiplies w = 1.0
	typedef struct packed {
		fix_t [3:0] r0;
		fix_t [3:0] r1;
		fix_t [3:0] r3;
	} vp_rows_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t w;
	} vtx_clip_t;

	typedef struct packed {
		vtx_clip_t [2:0] v;
	} tri_clip_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
	} vtx_ndc_t;

	typedef struct packed {
		vtx_ndc_t [2:0] v;
	} tri_ndc_t;

	typedef struct packed {
		scr_t [2:0] x;
		scr_t [2:0] y;
	} tri_screen_t;

	// e_init[i] is the edge from vertex i to vertex (i+1) mod 3
	typedef struct packed {
		scr_t [2:0] y;
		scr_t [2:0] e_init;
	} tri_setup_t;

	////////////////////////////////////////////////////////////////////////////
	// stage FSMs
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {XF_IDLE, XF_MAC, XF_LAST} xform_state_e;
	typedef enum logic [2:0] {DV_IDLE, DV_LOAD, DV_STEP, DV_STORE, DV_LAST} div_state_e;
	typedef enum logic [1:0] {ES_IDLE, ES_MUL, ES_LAST} edge_state_e;

endpackage

/* source/vs_transform.sv */
// i_vp is taken with each triangle; clip values wrap silently when they exceed Q8.8 range
`timescale 1ns/1ps
`include "vs_settings.svh"

module vs_transform (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_valid,
	input  vs_pkg::tri_world_t    i_tri,
	input  vs_pkg::vp_rows_t      i_vp,
	input  logic                  i_ready,
	output logic                  o_ready,
	output logic                  o_valid,
	output vs_pkg::tri_clip_t     o_clip
);

	localparam int ACC_W = 2 * `VS_FIX_W + 2;   // four full products

	vs_pkg::xform_state_e    state;
	vs_pkg::tri_world_t      tri_q;
	vs_pkg::vp_rows_t        vp_q;
	logic [1:0]              vtx_idx;   // vertex 0..2
	logic [1:0]              row_idx;   // 0 x, 1 y, 2 w
	logic [1:0]              term;      // column of the dot product
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] prod;
	logic signed [ACC_W-1:0] acc_next;
	vs_pkg::fix_t            op_vtx;
	vs_pkg::fix_t            op_row;
	vs_pkg::fix_t            dot_q;

	assign o_ready = (state == vs_pkg::XF_IDLE) && (!o_valid || i_ready);

	// shared multiply-accumulate operands
	always_comb begin
		case (term)
			2'd0: op_vtx = tri_q.v[vtx_idx].x;
			2'd1: op_vtx = tri_q.v[vtx_idx].y;
			2'd2: op_vtx = tri_q.v[vtx_idx].z;
			default: op_vtx = vs_pkg::fix_t'(1 << `VS_FRAC_WORLD);   // w = 1.0
		endcase
		case (row_idx)
			2'd0: op_row = vp_q.r0[term];
			2'd1: op_row = vp_q.r1[term];
			default: op_row = vp_q.r3[term];
		endcase
		prod = op_vtx * op_row;
		acc_next = (term == 2'd0) ? prod : acc + prod;
		dot_q = vs_pkg::fix_t'(acc_next >>> `VS_FRAC_WORLD);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= vs_pkg::XF_IDLE;
			o_valid <= 1'b0;
			vtx_idx <= '0;
			row_idx <= '0;
			term <= '0;
		end else begin
			if (o_valid && i_ready)
				o_valid <= 1'b0;
			case (state)
				vs_pkg::XF_IDLE: begin
					if (i_valid && o_ready)
						state <= vs_pkg::XF_MAC;
				end
				vs_pkg::XF_MAC: begin
					term <= term + 2'd1;   // wraps to 0 after column 3
					if (term == 2'd3) begin
						if (row_idx == 2'd2) begin
							row_idx <= '0;
							if (vtx_idx == 2'd2) begin
								vtx_idx <= '0;
								state <= vs_pkg::XF_LAST;
							end else begin
								vtx_idx <= vtx_idx + 2'd1;
							end
						end else begin
							row_idx <= row_idx + 2'd1;
						end
					end
				end
				vs_pkg::XF_LAST: begin
					o_valid <= 1'b1;
					state <= vs_pkg::XF_IDLE;
				end
				default: state <= vs_pkg::XF_IDLE;
			endcase
		end
	end

	// operands and results, written only while o_valid is low
	always_ff @(posedge clk) begin
		if (i_valid && o_ready) begin
			tri_q <= i_tri;
			vp_q <= i_vp;
		end
		if (state == vs_pkg::XF_MAC) begin
			acc <= acc_next;
			if (term == 2'd3) begin
				case (row_idx)
					2'd0: o_clip.v[vtx_idx].x <= dot_q;
					2'd1: o_clip.v[vtx_idx].y <= dot_q;
					default: o_clip.v[vtx_idx].w <= dot_q;
				endcase
			end
		end
	end

endmodule

/* source/vs_divide.sv */
// quotients are truncated to 16 bits without saturation; w = 0 gives ndc 0 after a full division time
`timescale 1ns/1ps
`include "vs_settings.svh"

module vs_divide (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_valid,
	input  vs_pkg::tri_clip_t  i_clip,
	input  logic               i_ready,
	output logic               o_ready,
	output logic               o_valid,
	output vs_pkg::tri_ndc_t   o_ndc
);

	localparam int CNT_W = $clog2(`VS_DIV_W);

	vs_pkg::div_state_e    state;
	vs_pkg::tri_clip_t     clip_q;
	logic [2:0]            pair;       // vertex in [2:1], y in [0]
	logic [CNT_W-1:0]      step;
	logic [`VS_DIV_W-1:0]  quo;        // dividend shifts out, quotient shifts in
	logic [`VS_FIX_W-1:0]  rem;
	logic [`VS_FIX_W-1:0]  den_mag;
	logic                  neg;
	logic                  den_zero;
	vs_pkg::fix_t          num;
	vs_pkg::fix_t          den;
	logic [`VS_FIX_W-1:0]  num_mag;
	logic [`VS_FIX_W:0]    rem_shift;
	vs_pkg::fix_t          q_signed;

	assign o_ready = (state == vs_pkg::DV_IDLE) && (!o_valid || i_ready);

	always_comb begin
		num = pair[0] ? clip_q.v[pair[2:1]].y : clip_q.v[pair[2:1]].x;
		den = clip_q.v[pair[2:1]].w;
		num_mag = num[`VS_FIX_W-1] ? -num : num;   // -32768 still fits unsigned
		rem_shift = {rem, quo[`VS_DIV_W-1]};
		q_signed = neg ? -quo[`VS_FIX_W-1:0] : quo[`VS_FIX_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= vs_pkg::DV_IDLE;
			o_valid <= 1'b0;
			pair <= '0;
			step <= '0;
		end else begin
			if (o_valid && i_ready)
				o_valid <= 1'b0;
			case (state)
				vs_pkg::DV_IDLE:  if (i_valid && o_ready) state <= vs_pkg::DV_LOAD;
				vs_pkg::DV_LOAD: begin
					step <= '0;
					state <= vs_pkg::DV_STEP;
				end
				vs_pkg::DV_STEP: begin
					step <= step + 1'b1;
					if (step == CNT_W'(`VS_DIV_W - 1))
						state <= vs_pkg::DV_STORE;
				end
				vs_pkg::DV_STORE: begin
					if (pair == 3'd5) begin
						pair <= '0;
						state <= vs_pkg::DV_LAST;
					end else begin
						pair <= pair + 3'd1;
						state <= vs_pkg::DV_LOAD;
					end
				end
				vs_pkg::DV_LAST: begin
					o_valid <= 1'b1;
					state <= vs_pkg::DV_IDLE;
				end
				default: state <= vs_pkg::DV_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// restoring divider datapath
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (i_valid && o_ready)
			clip_q <= i_clip;
		case (state)
			vs_pkg::DV_LOAD: begin
				quo <= {num_mag, {`VS_FRAC_NDC{1'b0}}};   // clip << 14
				rem <= '0;
				den_mag <= den[`VS_FIX_W-1] ? -den : den;
				neg <= num[`VS_FIX_W-1] ^ den[`VS_FIX_W-1];
				den_zero <= (den == '0);
			end
			vs_pkg::DV_STEP: begin
				if (rem_shift >= {1'b0, den_mag}) begin
					rem <= `VS_FIX_W'(rem_shift - {1'b0, den_mag});
					quo <= {quo[`VS_DIV_W-2:0], 1'b1};
				end else begin
					rem <= rem_shift[`VS_FIX_W-1:0];
					quo <= {quo[`VS_DIV_W-2:0], 1'b0};
				end
			end
			vs_pkg::DV_STORE: begin
				if (pair[0])
					o_ndc.v[pair[2:1]].y <= den_zero ? '0 : q_signed;
				else
					o_ndc.v[pair[2:1]].x <= den_zero ? '0 : q_signed;
			end
			default: ;
		endcase
	end

endmodule

/* source/vs_viewport.sv */
// ndc outside [-2, 2) has already wrapped in vs_divide; screen values are not clipped
`timescale 1ns/1ps
`include "vs_settings.svh"

module vs_viewport (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_valid,
	input  vs_pkg::tri_ndc_t     i_ndc,
	input  logic                 i_ready,
	output logic                 o_ready,
	output logic                 o_valid,
	output vs_pkg::tri_screen_t  o_screen
);

	localparam int WIDE_W = `VS_FIX_W + 10;   // room for ndc * 320

	// floor(ndc * half) + half, shift-add only
	function automatic vs_pkg::scr_t to_screen(input vs_pkg::fix_t ndc, input logic is_y);
		logic signed [WIDE_W-1:0] wide;
		logic signed [WIDE_W-1:0] scaled;
		wide = ndc;
		if (is_y)
			scaled = (wide <<< 8) - (wide <<< 4);   // 240 = 256 - 16
		else
			scaled = (wide <<< 8) + (wide <<< 6);   // 320 = 256 + 64
		scaled = scaled >>> `VS_FRAC_NDC;
		return vs_pkg::scr_t'(scaled + (is_y ? `VS_HALF_H : `VS_HALF_W));
	endfunction

	assign o_ready = !o_valid || i_ready;

	always_ff @(posedge clk) begin
		if (reset)
			o_valid <= 1'b0;
		else if (i_valid && o_ready)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (i_valid && o_ready) begin
			for (int i = 0; i < 3; i++) begin
				o_screen.x[i] <= to_screen(i_ndc.v[i].x, 1'b0);
				o_screen.y[i] <= to_screen(i_ndc.v[i].y, 1'b1);
			end
		end
	end

endmodule

/* source/vs_edge_setup.sv */
// edge values wrap to 20 bits; vertex order decides the sign of each edge
`timescale 1ns/1ps
`include "vs_settings.svh"

module vs_edge_setup (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_valid,
	input  vs_pkg::tri_screen_t  i_screen,
	input  logic                 i_ready,
	output logic                 o_ready,
	output logic                 o_valid,
	output vs_pkg::tri_setup_t   o_setup
);

	vs_pkg::edge_state_e           state;
	vs_pkg::tri_screen_t           scr_q;
	logic [1:0]                    edge_idx;   // edge i runs from vertex i to j
	logic [1:0]                    j_idx;
	logic                          second;     // 0 y_i*(x_j-x_i), 1 x_i*(y_i-y_j)
	vs_pkg::scr_t                  mul_a;
	vs_pkg::scr_t                  mul_b;
	logic signed [2*`VS_SCR_W-1:0] prod;
	vs_pkg::scr_t                  tmp;

	assign o_ready = (state == vs_pkg::ES_IDLE) && (!o_valid || i_ready);
	assign j_idx = (edge_idx == 2'd2) ? 2'd0 : edge_idx + 2'd1;

	// one shared 20x20 multiplier
	always_comb begin
		if (second) begin
			mul_a = scr_q.x[edge_idx];
			mul_b = scr_q.y[edge_idx] - scr_q.y[j_idx];
		end else begin
			mul_a = scr_q.y[edge_idx];
			mul_b = scr_q.x[j_idx] - scr_q.x[edge_idx];
		end
		prod = mul_a * mul_b;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= vs_pkg::ES_IDLE;
			o_valid <= 1'b0;
			edge_idx <= '0;
			second <= 1'b0;
		end else begin
			if (o_valid && i_ready)
				o_valid <= 1'b0;
			case (state)
				vs_pkg::ES_IDLE: if (i_valid && o_ready) state <= vs_pkg::ES_MUL;
				vs_pkg::ES_MUL: begin
					second <= ~second;
					if (second) begin
						if (edge_idx == 2'd2) begin
							edge_idx <= '0;
							state <= vs_pkg::ES_LAST;
						end else begin
							edge_idx <= edge_idx + 2'd1;
						end
					end
				end
				vs_pkg::ES_LAST: begin
					o_valid <= 1'b1;
					state <= vs_pkg::ES_IDLE;
				end
				default: state <= vs_pkg::ES_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid && o_ready)
			scr_q <= i_screen;
		if (state == vs_pkg::ES_MUL) begin
			if (second)
				o_setup.e_init[edge_idx] <= tmp - vs_pkg::scr_t'(prod);
			else
				tmp <= vs_pkg::scr_t'(prod);   // low 20 bits are enough
		end
		if (state == vs_pkg::ES_LAST)
			o_setup.y <= scr_q.y;
	end

endmodule

/* source/vs_top.sv */
// four stages hold up to four triangles; i_vp must be valid together with i_tri
`timescale 1ns/1ps

module vs_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_valid,
	input  vs_pkg::tri_world_t  i_tri,
	input  vs_pkg::vp_rows_t    i_vp,
	input  logic                i_ready,
	output logic                o_ready,
	output logic                o_valid,
	output vs_pkg::tri_setup_t  o_setup
);

	////////////////////////////////////////////////////////////////////////////
	// stage boundaries
	////////////////////////////////////////////////////////////////////////////
	vs_pkg::tri_clip_t    clip;
	vs_pkg::tri_ndc_t     ndc;
	vs_pkg::tri_screen_t  screen;
	logic                 clip_valid, clip_ready;
	logic                 ndc_valid, ndc_ready;
	logic                 screen_valid, screen_ready;

	vs_transform u_transform (
		.clk(clk), .reset(reset),
		.i_valid(i_valid), .i_tri(i_tri), .i_vp(i_vp), .o_ready(o_ready),
		.o_valid(clip_valid), .o_clip(clip), .i_ready(clip_ready)
	);

	vs_divide u_divide (
		.clk(clk), .reset(reset),
		.i_valid(clip_valid), .i_clip(clip), .o_ready(clip_ready),
		.o_valid(ndc_valid), .o_ndc(ndc), .i_ready(ndc_ready)
	);

	vs_viewport u_viewport (
		.clk(clk), .reset(reset),
		.i_valid(ndc_valid), .i_ndc(ndc), .o_ready(ndc_ready),
		.o_valid(screen_valid), .o_screen(screen), .i_ready(screen_ready)
	);

	vs_edge_setup u_edge_setup (
		.clk(clk), .reset(reset),
		.i_valid(screen_valid), .i_screen(screen), .o_ready(screen_ready),
		.o_valid(o_valid), .o_setup(o_setup), .i_ready(i_ready)
	);

endmodule

/* verif/vs_tb_clock.sv */
// free-running testbench clock starting low; the period is given in ns
`timescale 1ns/1ps

module vs_tb_clock #(
	parameter real PERIOD_NS = 100.0
) (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #(PERIOD_NS / 2.0) o_clk = ~o_clk;   // first rising edge at half a period

endmodule

/* verif/vs_assert.sv */
// bound to vs_top; checks the output handshake and X on the input side only, not data values
`timescale 1ns/1ps

module vs_assert (
	input logic               clk,
	input logic               reset,
	input logic               i_valid,
	input logic               i_ready,
	input logic               o_ready,
	input logic               o_valid,
	input vs_pkg::tri_setup_t o_setup
);

	// result held while the sink stalls
	property hold_while_stalled;
		@(posedge clk) disable iff (reset)
		o_valid && !i_ready |=> o_valid && $stable(o_setup);
	endproperty

	hold_a: assert property (hold_while_stalled)
		else $error("o_valid or o_setup changed while i_ready was low");

	reset_a: assert property (@(posedge clk) reset |=> !o_valid)
		else $error("o_valid high in the cycle after reset");

	known_a: assert property (@(posedge clk) disable iff (reset) !$isunknown({o_ready, i_valid}))
		else $error("X on o_ready or i_valid");

endmodule

bind vs_top vs_assert u_assert (
	.clk(clk), .reset(reset),
	.i_valid(i_valid), .i_ready(i_ready),
	.o_ready(o_ready), .o_valid(o_valid), .o_setup(o_setup)
);

/* verif/vs_tb.sv */
// eight table triangles run three times: one at a time, back to back, and with random i_ready
`timescale 1ns/1ps
`include "vs_settings.svh"

module vs_tb;

	localparam int N_TRI = 8;
	localparam int TIMEOUT = 3000;   // cycles per wait
	localparam int W0_ENTRY = 3;     // vertex 1 has w = 0

	typedef struct packed {
		vs_pkg::tri_world_t world;
		vs_pkg::vp_rows_t   vp;
		vs_pkg::tri_setup_t exp;
	} entry_t;

	logic               clk;
	logic               reset;
	logic               i_valid;
	vs_pkg::tri_world_t i_tri;
	vs_pkg::vp_rows_t   i_vp;
	logic               i_ready;
	logic               o_ready;
	logic               o_valid;
	vs_pkg::tri_setup_t o_setup;

	entry_t      stim [N_TRI];
	int          expect_q [$];   // table indices in input order
	logic [31:0] lfsr;
	int          checks, mismatches, timeouts, others;
	int          max_inflight;
	int          stalls;         // cycles a waiting result was held back
	bit          timed_out;

	vs_tb_clock #(.PERIOD_NS(100.0)) u_clock (.o_clk(clk));

	vs_top dut (
		.clk(clk), .reset(reset),
		.i_valid(i_valid), .i_tri(i_tri), .i_vp(i_vp), .o_ready(o_ready),
		.o_valid(o_valid), .o_setup(o_setup), .i_ready(i_ready)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic longint clip_dot(input vs_pkg::vtx_world_t v, input vs_pkg::fix_t [3:0] row);
		longint sum;
		sum = longint'(row[0]) * longint'(v.x) + longint'(row[1]) * longint'(v.y)
			+ longint'(row[2]) * longint'(v.z) + (longint'(row[3]) << `VS_FRAC_WORLD);
		return longint'(vs_pkg::fix_t'(sum >>> `VS_FRAC_WORLD));   // wraps to Q8.8
	endfunction

	function automatic longint ndc_div(input longint num, input longint den);
		if (den == 0)
			return 0;
		return longint'(vs_pkg::fix_t'((num << `VS_FRAC_NDC) / den));   // toward zero
	endfunction

	function automatic vs_pkg::tri_setup_t model_setup(input vs_pkg::tri_world_t t,
			input vs_pkg::vp_rows_t m);
		vs_pkg::tri_setup_t s;
		longint sx [3];
		longint sy [3];
		longint w;
		int j;
		for (int i = 0; i < 3; i++) begin
			w = clip_dot(t.v[i], m.r3);
			sx[i] = ((ndc_div(clip_dot(t.v[i], m.r0), w) * `VS_HALF_W) >>> `VS_FRAC_NDC) + `VS_HALF_W;
			sy[i] = ((ndc_div(clip_dot(t.v[i], m.r1), w) * `VS_HALF_H) >>> `VS_FRAC_NDC) + `VS_HALF_H;
		end
		for (int i = 0; i < 3; i++) begin
			j = (i + 1) % 3;
			s.y[i] = vs_pkg::scr_t'(sy[i]);
			s.e_init[i] = vs_pkg::scr_t'(sy[i] * (sx[j] - sx[i]) - sx[i] * (sy[i] - sy[j]));
		end
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus table in 1/256 units
	////////////////////////////////////////////////////////////////////////////
	function automatic vs_pkg::vp_rows_t pack_rows(input int a0, a1, a2, a3,
			input int b0, b1, b2, b3, input int c0, c1, c2, c3);
		vs_pkg::vp_rows_t m;
		m.r0 = {vs_pkg::fix_t'(a3), vs_pkg::fix_t'(a2), vs_pkg::fix_t'(a1), vs_pkg::fix_t'(a0)};
		m.r1 = {vs_pkg::fix_t'(b3), vs_pkg::fix_t'(b2), vs_pkg::fix_t'(b1), vs_pkg::fix_t'(b0)};
		m.r3 = {vs_pkg::fix_t'(c3), vs_pkg::fix_t'(c2), vs_pkg::fix_t'(c1), vs_pkg::fix_t'(c0)};
		return m;
	endfunction

	function automatic vs_pkg::tri_world_t world_tri(input int x0, y0, z0,
			input int x1, y1, z1, input int x2, y2, z2);
		vs_pkg::tri_world_t t;
		t.v[0] = {vs_pkg::fix_t'(x0), vs_pkg::fix_t'(y0), vs_pkg::fix_t'(z0)};
		t.v[1] = {vs_pkg::fix_t'(x1), vs_pkg::fix_t'(y1), vs_pkg::fix_t'(z1)};
		t.v[2] = {vs_pkg::fix_t'(x2), vs_pkg::fix_t'(y2), vs_pkg::fix_t'(z2)};
		return t;
	endfunction

	task automatic load_table();
		vs_pkg::vp_rows_t ident;
		vs_pkg::vp_rows_t persp;
		ident = pack_rows(256, 0, 0, 0, 0, 256, 0, 0, 0, 0, 0, 256);
		persp = pack_rows(256, 0, 0, 0, 0, 256, 0, 0, 0, 0, 256, 0);   // w = z
		stim[0].world = world_tri(128, 64, 0, -128, 192, 0, 64, -128, 0);
		stim[0].vp = ident;
		stim[1].world = world_tri(256, -256, 0, -320, 128, 0, 0, 384, 0);
		stim[1].vp = ident;
		stim[2].world = world_tri(-384, 256, 512, 256, -128, 384, 128, 128, 256);
		stim[2].vp = persp;
		stim[3].world = world_tri(128, 128, 256, 256, 256, 0, -128, 64, 512);
		stim[3].vp = persp;
		stim[4].world = world_tri(-256, -256, 384, 192, -64, 128, 96, 160, 640);
		stim[4].vp = pack_rows(256, 0, 0, 0, 0, 256, 0, 0, 0, 0, 256, 128);
		stim[5].world = world_tri(256, 256, 0, -384, 128, 0, 128, -320, 0);
		stim[5].vp = pack_rows(128, 0, 0, 64, 0, 192, 0, -32, 0, 0, 0, 256);
		stim[6].world = world_tri(256, 128, -512, -192, 64, -256, 64, -128, -128);
		stim[6].vp = persp;   // negative w flips the signs
		stim[7].world = world_tri(256, 128, 128, -128, 256, 256, 192, -192, -256);
		stim[7].vp = pack_rows(128, -128, 0, 0, 128, 128, 0, 0, 0, 0, 128, 256);
		for (int i = 0; i < N_TRI; i++)
			stim[i].exp = model_setup(stim[i].world, stim[i].vp);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// back-pressure source and checks
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
		return b;
	endfunction

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_scr(input string name, input vs_pkg::scr_t got, input vs_pkg::scr_t exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_setup(input vs_pkg::tri_setup_t got, input vs_pkg::tri_setup_t exp);
		for (int i = 0; i < 3; i++) begin
			check_scr($sformatf("o_setup.y[%0d]", i), got.y[i], exp.y[i]);
			check_scr($sformatf("o_setup.e_init[%0d]", i), got.e_init[i], exp.e_init[i]);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		timeouts++;
		timed_out = 1'b1;
	endtask

	// inputs change 1 ns after the edge; handshakes sampled at the falling edge
	task automatic send_all(input bit one_at_a_time);
		int  waited;
		bit  accepted;
		@(posedge clk);
		#1;
		for (int i = 0; i < N_TRI && !timed_out; i++) begin
			waited = 0;
			while (one_at_a_time && expect_q.size() != 0 && !timed_out) begin
				@(posedge clk);
				#1;
				waited++;
				if (waited > TIMEOUT)
					report_timeout("previous triangle never came out");
			end
			i_valid = 1'b1;
			i_tri = stim[i].world;
			i_vp = stim[i].vp;
			accepted = 1'b0;
			waited = 0;
			while (!accepted && !timed_out) begin
				@(negedge clk);
				if (o_ready) begin
					accepted = 1'b1;
					expect_q.push_back(i);
				end
				@(posedge clk);
				#1;
				waited++;
				if (!accepted && waited > TIMEOUT)
					report_timeout("o_ready stayed low with a triangle waiting");
			end
			i_valid = 1'b0;
		end
	endtask

	task automatic collect(input bit random_ready);
		int got;
		int waited;
		int idx;
		got = 0;
		waited = 0;
		while (got < N_TRI && !timed_out) begin
			@(posedge clk);
			#1;
			if (expect_q.size() > max_inflight)
				max_inflight = expect_q.size();
			i_ready = random_ready ? (take_bit() & take_bit()) : 1'b1;   // about 1/4 high
			@(negedge clk);
			if (o_valid && !i_ready)
				stalls++;
			if (o_valid && i_ready) begin
				if (expect_q.size() == 0) begin
					$display("a result came out with no triangle outstanding");
					others++;
				end else begin
					idx = expect_q.pop_front();
					check_setup(o_setup, stim[idx].exp);
					if (idx == W0_ENTRY)
						check_scr("o_setup.y[1]", o_setup.y[1], vs_pkg::scr_t'(`VS_HALF_H));
				end
				got++;
				waited = 0;
			end else begin
				waited++;
				if (waited > TIMEOUT)
					report_timeout("o_valid did not rise for an outstanding triangle");
			end
		end
	endtask

	initial begin
		int extra;
		reset = 1'b1;
		i_valid = 1'b0;
		i_tri = '0;
		i_vp = '0;
		i_ready = 1'b0;
		lfsr = 32'd69454;
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		others = 0;
		max_inflight = 0;
		stalls = 0;
		timed_out = 1'b0;
		extra = 0;
		load_table();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_flag("o_valid", o_valid, 1'b0);
		check_flag("o_ready", o_ready, 1'b1);

		// single, back to back, back to back with stalls
		for (int pass = 0; pass < 3; pass++) begin
			if (pass == 1)
				max_inflight = 0;
			fork
				send_all(pass == 0);
				collect(pass == 2);
			join
			if (pass == 1 && max_inflight < 2) begin
				$display("fewer than two triangles were in flight back to back");
				others++;
			end
			if (pass == 2 && stalls == 0) begin
				$display("random i_ready never held back a waiting result");
				others++;
			end
		end

		// nothing more may come out
		@(posedge clk);
		#1;
		i_ready = 1'b1;
		repeat (250) begin
			@(negedge clk);
			if (o_valid)
				extra++;
		end
		if (extra != 0 || expect_q.size() != 0) begin
			$display("%0d extra result cycles, %0d triangles lost", extra, expect_q.size());
			others++;
		end

		$display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
			checks, mismatches, timeouts, others);
		if (mismatches == 0 && timeouts == 0 && others == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+source
source/vs_pkg.sv
source/vs_transform.sv
source/vs_divide.sv
source/vs_viewport.sv
source/vs_edge_setup.sv
source/vs_top.sv
verif/vs_tb_clock.sv
verif/vs_assert.sv
verif/vs_tb.sv

/* run.sh */
#!/bin/sh
# builds vs_tb with Verilator, runs it and scans the log; exits 0 only on a pass
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module vs_tb -Mdir obj_dir -o vs_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/vs_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
